// File: files.f
hdl/alu_pkg.sv
hdl/exec_pkg.sv
hdl/byte_lane_unit.sv
hdl/alu.sv
hdl/exec_stage.sv
testbench/exec_assert.sv
testbench/exec_tb.sv

// File: hdl/alu.sv
// Combinational 32-bit ALU: arithmetic, logic, shifts, byte lanes, counter read and flags
module alu
  import alu_pkg::*;
  import exec_pkg::*;
#(
  parameter int PERF_W = 16
) (
  input  alu_op_e    op,
  input  word_t      in0,
  input  word_t      in1,
  input  shamt_t     shamt,
  input  perf_cnt_t  perf_cnt,
  output word_t      result,
  output alu_flags_t flags
);

  // Keeps the low PERF_W bits of the counter
  localparam word_t PERF_MASK = word_t'({WORD_W{1'b1}} >> (WORD_W - PERF_W));

  word_t    add_res;
  word_t    sub_res;
  word_t    sll_res;
  word_t    srl_res;
  word_t    sra_res;
  word_t    lane_res;
  byte_op_e lane_op;
  logic     add_ovf;
  logic     sub_ovf;

  assign add_res = in0 + in1;
  assign sub_res = in0 - in1;

  assign sll_res = in0 << shamt;
  assign srl_res = in0 >> shamt;
  // Sign bit fills from the left
  assign sra_res = word_t'($signed(in0) >>> shamt);

  // Signed overflow: operand signs vs. result sign
  assign add_ovf = (in0[WORD_W-1] == in1[WORD_W-1]) &&
                   (add_res[WORD_W-1] != in0[WORD_W-1]);
  assign sub_ovf = (in0[WORD_W-1] != in1[WORD_W-1]) &&
                   (sub_res[WORD_W-1] != in0[WORD_W-1]);

  // Byte op code to lane unit op
  always_comb begin
    case (op)
      ADDBI:   lane_op = LANE_ADDI;
      SUBB:    lane_op = LANE_SUB;
      SUBBI:   lane_op = LANE_SUBI;
      default: lane_op = LANE_ADD;
    endcase
  end

  byte_lane_unit byte_lane_unit_i (
    .in0     (in0),
    .in1     (in1),
    .lane_op (lane_op),
    .lanes   (lane_res)
  );

  // Result select
  always_comb begin
    case (op)
      ADD:   result = add_res;
      SUB:   result = sub_res;
      LUI:   result = {in1[WORD_W/2-1:0], {(WORD_W/2){1'b0}}};
      MOV:   result = in0;
      AND:   result = in0 & in1;
      OR:    result = in0 | in1;
      XOR:   result = in0 ^ in1;
      NOT:   result = ~in0;
      SLL:   result = sll_res;
      SRL:   result = srl_res;
      SRA:   result = sra_res;
      ADDB,
      ADDBI,
      SUBB,
      SUBBI: result = lane_res;
      // Counter value before this instruction is counted
      LLDC:  result = perf_cnt & PERF_MASK;
      default: begin
        result = '0;
      end
    endcase
  end

  // Flags
  assign flags.z = (result == '0);
  assign flags.n = result[WORD_W-1];

  // Overflow only for the 32-bit add and subtract
  always_comb begin
    case (op)
      ADD:     flags.v = add_ovf;
      SUB:     flags.v = sub_ovf;
      default: flags.v = 1'b0;
    endcase
  end

endmodule

// File: hdl/alu_pkg.sv
// ALU widths, word, lane and shift types, operation enums and flag struct
package alu_pkg;

  // Datapath geometry
  localparam int WORD_W    = 32;
  localparam int BYTE_W    = 8;
  localparam int SHAMT_W   = 5;
  localparam int NUM_LANES = WORD_W / BYTE_W;

  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [BYTE_W-1:0]  byte_t;
  typedef logic [SHAMT_W-1:0] shamt_t;

  // Operation code, encoded 0 to 15 in this order
  typedef enum logic [3:0] {
    ADD,
    SUB,
    LUI,
    MOV,
    AND,
    OR,
    XOR,
    NOT,
    SLL,
    SRL,
    SRA,
    ADDB,
    ADDBI,
    SUBB,
    SUBBI,
    LLDC
  } alu_op_e;

  // Operation handed to the byte-lane unit
  typedef enum logic [1:0] {
    LANE_ADD,
    LANE_ADDI,
    LANE_SUB,
    LANE_SUBI
  } byte_op_e;

  // Zero, negative and signed overflow
  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } alu_flags_t;

endpackage

// File: hdl/byte_lane_unit.sv
// Four-lane byte unit with saturating add, wrapping subtract and immediate operand forms
module byte_lane_unit
  import alu_pkg::*;
(
  input  word_t    in0,
  input  word_t    in1,
  input  byte_op_e lane_op,
  output word_t    lanes
);

  logic is_imm;
  logic is_sub;

  // Immediate forms take the second operand of every lane from in1[7:0]
  assign is_imm = (lane_op == LANE_ADDI) || (lane_op == LANE_SUBI);
  assign is_sub = (lane_op == LANE_SUB) || (lane_op == LANE_SUBI);

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    byte_t           op_a;
    byte_t           op_b;
    logic [BYTE_W:0] sum;
    byte_t           diff;
    byte_t           res;

    // Lanes 0 and 1 always use their own byte of in0
    if (i < 2) begin : g_low
      assign op_a = in0[i*BYTE_W +: BYTE_W];
    end else begin : g_high
      // Lanes 2 and 3 repeat in0[15:8] in the immediate forms
      assign op_a = is_imm ? in0[2*BYTE_W-1:BYTE_W] : in0[i*BYTE_W +: BYTE_W];
    end

    assign op_b = is_imm ? in1[BYTE_W-1:0] : in1[i*BYTE_W +: BYTE_W];

    // Nine-bit sum keeps the lane carry
    assign sum  = {1'b0, op_a} + {1'b0, op_b};
    assign diff = op_a - op_b;

    // Carry out of the lane clamps it to 0xFF while subtract wraps
    always_comb begin
      if (is_sub) begin
        res = diff;
      end else if (sum[BYTE_W]) begin
        res = {BYTE_W{1'b1}};
      end else begin
        res = sum[BYTE_W-1:0];
      end
    end

    assign lanes[i*BYTE_W +: BYTE_W] = res;
  end

endmodule

// File: hdl/exec_pkg.sv
// Execute stage request and response structs and performance count type
package exec_pkg;

  import alu_pkg::*;

  // Counter container, only the low PERF_W bits are ever non-zero
  typedef logic [WORD_W-1:0] perf_cnt_t;

  // One instruction issued to the stage
  typedef struct packed {
    alu_op_e op;
    word_t   in0;
    word_t   in1;
    shamt_t  shamt;
  } exec_req_t;

  // Registered ALU output
  typedef struct packed {
    word_t      result;
    alu_flags_t flags;
  } exec_rsp_t;

endpackage

// File: hdl/exec_stage.sv
// Execute stage top: ALU, instruction counter and one-cycle response register
module exec_stage
  import alu_pkg::*;
  import exec_pkg::*;
#(
  parameter int PERF_W = 16
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      req_valid,
  input  exec_req_t req,
  output logic      rsp_valid,
  output exec_rsp_t rsp,
  output perf_cnt_t perf_cnt
);

  logic [PERF_W-1:0] cnt_q;
  word_t             alu_result;
  alu_flags_t        alu_flags;

  // Upper counter bits read as zero
  assign perf_cnt = perf_cnt_t'(cnt_q);

  // ALU sees the count before the current request is counted
  alu #(
    .PERF_W (PERF_W)
  ) alu_i (
    .op       (req.op),
    .in0      (req.in0),
    .in1      (req.in1),
    .shamt    (req.shamt),
    .perf_cnt (perf_cnt),
    .result   (alu_result),
    .flags    (alu_flags)
  );

  // Accepted instruction count, wraps at 2^PERF_W
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q <= '0;
    end else if (req_valid) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Valid strobe follows the request one cycle later
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= req_valid;
    end
  end

  // Response holds its value through idle cycles
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp <= '0;
    end else if (req_valid) begin
      rsp.result <= alu_result;
      rsp.flags  <= alu_flags;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# Build the execute stage testbench with Verilator, run it and look for the pass line

rm -f sim.log && \
verilator --binary --assert -Wno-fatal --top-module exec_tb -f files.f -o exec_sim && \
./obj_dir/exec_sim | tee sim.log && \
grep -q '^STATUS: PASS$' sim.log && \
echo "run passed" || {
  echo "run failed"
  exit 1
}

// File: testbench/exec_assert.sv
// Concurrent assertions on the execute stage response, bound into exec_stage
module exec_assert
  import exec_pkg::*;
(
  input logic      clk,
  input logic      arst_n,
  input logic      rsp_valid,
  input exec_rsp_t rsp
);

  // No response while reset is held
  rsp_idle_in_reset: assert property (@(posedge clk) !arst_n |-> !rsp_valid)
    else $error("rsp_valid is high while arst_n is asserted");

  // Zero flag follows an all-zero result
  zero_flag_match: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_valid |-> (rsp.flags.z == (rsp.result == '0)))
    else $error("flags.z does not match the result");

  // Negative flag copies the sign bit
  neg_flag_match: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_valid |-> (rsp.flags.n == rsp.result[31]))
    else $error("flags.n does not match result bit 31");

  rsp_known: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_valid |-> !$isunknown(rsp))
    else $error("rsp has unknown bits while rsp_valid is high");

endmodule

bind exec_stage exec_assert exec_assert_i (
  .clk       (clk),
  .arst_n    (arst_n),
  .rsp_valid (rsp_valid),
  .rsp       (rsp)
);

// File: testbench/exec_tb.sv
// Execute stage testbench: clock, reset, directed and random stimulus, reference model, checks
module exec_tb
  import alu_pkg::*;
  import exec_pkg::*;
();

  localparam int PERF_W     = 16;
  localparam int CLK_PERIOD = 8;
  localparam int NUM_RANDOM = 2000;
  // 2000 random cycles, about 50 reset and directed cycles, plus margin
  localparam int MAX_CYCLES = 2400;

  logic      clk;
  logic      arst_n;
  logic      req_valid;
  exec_req_t req;
  logic      rsp_valid;
  exec_rsp_t rsp;
  perf_cnt_t perf_cnt;

  integer            seed;
  int                cycles = 0;
  logic [PERF_W-1:0] model_cnt;
  logic [PERF_W-1:0] acc_cnt;
  logic              pend_valid;
  exec_rsp_t         last_rsp;
  exec_rsp_t         exp_q[$];

  exec_stage #(
    .PERF_W (PERF_W)
  ) dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .perf_cnt  (perf_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic compare(input string what, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("Error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // Four lanes, 8-bit add saturating at 255 or subtract modulo 256
  function automatic word_t lane_model(input word_t in0, input word_t in1,
                                       input logic imm, input logic sub);
    word_t res;
    int    a;
    int    b;
    int    s;
    for (int i = 0; i < 4; i++) begin
      a = (imm && i > 0) ? int'(in0[15:8]) : int'(in0[8*i +: 8]);
      b = imm ? int'(in1[7:0]) : int'(in1[8*i +: 8]);
      if (sub) begin
        s = (a - b) & 255;
      end else begin
        s = (a + b > 255) ? 255 : a + b;
      end
      res[8*i +: 8] = s[7:0];
    end
    return res;
  endfunction

  function automatic exec_rsp_t model(input exec_req_t r, input logic [PERF_W-1:0] cnt);
    exec_rsp_t e;
    word_t     res;
    longint    exact;
    logic      v;
    v = 1'b0;
    case (r.op)
      ADD: begin
        res   = r.in0 + r.in1;
        exact = longint'($signed(r.in0)) + longint'($signed(r.in1));
        v     = exact != longint'($signed(res));
      end
      SUB: begin
        res   = r.in0 - r.in1;
        exact = longint'($signed(r.in0)) - longint'($signed(r.in1));
        v     = exact != longint'($signed(res));
      end
      LUI:   res = {r.in1[15:0], 16'h0000};
      MOV:   res = r.in0;
      AND:   res = r.in0 & r.in1;
      OR:    res = r.in0 | r.in1;
      XOR:   res = r.in0 ^ r.in1;
      NOT:   res = ~r.in0;
      SLL:   res = r.in0 << r.shamt;
      SRL:   res = r.in0 >> r.shamt;
      SRA: begin
        res = r.in0 >> r.shamt;
        if (r.in0[31]) begin
          res = res | ~(32'hffff_ffff >> r.shamt);
        end
      end
      ADDB:  res = lane_model(r.in0, r.in1, 1'b0, 1'b0);
      ADDBI: res = lane_model(r.in0, r.in1, 1'b1, 1'b0);
      SUBB:  res = lane_model(r.in0, r.in1, 1'b0, 1'b1);
      SUBBI: res = lane_model(r.in0, r.in1, 1'b1, 1'b1);
      default: res = word_t'(cnt);
    endcase
    e.result  = res;
    e.flags.z = (res == 32'd0);
    e.flags.n = res[31];
    e.flags.v = v;
    return e;
  endfunction

  // Response of the request accepted at the last rising edge
  task automatic check_outputs();
    exec_rsp_t expd;
    compare("rsp_valid", word_t'(rsp_valid), word_t'(pend_valid));
    if (pend_valid) begin
      expd     = exp_q.pop_front();
      last_rsp = expd;
      acc_cnt  = acc_cnt + 16'd1;
    end
    compare("result", rsp.result, last_rsp.result);
    compare("flags", word_t'(rsp.flags), word_t'(last_rsp.flags));
    compare("perf_cnt", perf_cnt, word_t'(acc_cnt));
  endtask

  task automatic issue(input logic valid, input alu_op_e op, input word_t in0,
                       input word_t in1, input shamt_t shamt);
    exec_req_t r;
    r.op    = op;
    r.in0   = in0;
    r.in1   = in1;
    r.shamt = shamt;
    @(posedge clk);
    req_valid <= valid;
    req       <= r;
    if (valid) begin
      exp_q.push_back(model(r, model_cnt));
      model_cnt = model_cnt + 16'd1;
    end
    @(negedge clk);
    check_outputs();
    pend_valid = valid;
  endtask

  // Biased toward the corner values that set flags
  function automatic word_t pick_operand();
    logic [31:0] sel;
    word_t       pick;
    sel = $random(seed);
    case (sel[2:0])
      3'd0:    pick = 32'h0000_0000;
      3'd1:    pick = 32'hffff_ffff;
      3'd2:    pick = 32'h8000_0000;
      3'd3:    pick = 32'h7fff_ffff;
      default: pick = $random(seed);
    endcase
    return pick;
  endfunction

  task automatic idle(input int n);
    repeat (n) issue(1'b0, alu_op_e'(4'($random(seed))), pick_operand(), pick_operand(), '0);
  endtask

  task automatic run_directed();
    // Signed overflow and zero results
    issue(1'b1, ADD, 32'h7fff_ffff, 32'h0000_0001, '0);
    issue(1'b1, ADD, 32'h8000_0000, 32'h8000_0000, '0);
    issue(1'b1, ADD, 32'hffff_ffff, 32'h0000_0001, '0);
    issue(1'b1, SUB, 32'h8000_0000, 32'h0000_0001, '0);
    issue(1'b1, SUB, 32'h7fff_ffff, 32'hffff_ffff, '0);
    issue(1'b1, SUB, 32'h1234_5678, 32'h1234_5678, '0);
    issue(1'b1, XOR, 32'hdead_beef, 32'hdead_beef, '0);
    issue(1'b1, LUI, 32'hdead_beef, 32'hffff_1234, '0);
    // Byte lanes, saturation and wrap
    issue(1'b1, ADDB, 32'hffff_ffff, 32'hffff_ffff, '0);
    issue(1'b1, ADDBI, 32'hffff_ffff, 32'hffff_ffff, '0);
    issue(1'b1, ADDB, 32'h7f80_10f0, 32'h0180_ef20, '0);
    issue(1'b1, ADDBI, 32'h1234_5601, 32'h0000_0005, '0);
    issue(1'b1, SUBB, 32'h0001_0203, 32'h0101_0101, '0);
    issue(1'b1, SUBBI, 32'hffff_1002, 32'h0000_0003, '0);
    // Shift edges with negative operands
    issue(1'b1, SLL, 32'h8000_0001, '0, 5'd0);
    issue(1'b1, SLL, 32'h8000_0001, '0, 5'd31);
    issue(1'b1, SRL, 32'hf000_000f, '0, 5'd0);
    issue(1'b1, SRL, 32'hf000_000f, '0, 5'd31);
    issue(1'b1, SRA, 32'hf000_000f, '0, 5'd0);
    issue(1'b1, SRA, 32'h8000_0001, '0, 5'd4);
    issue(1'b1, SRA, 32'h8000_0001, '0, 5'd31);
    // Counter reads around idle gaps
    idle(3);
    issue(1'b1, LLDC, '0, '0, '0);
    issue(1'b1, LLDC, '0, '0, '0);
    idle(1);
    issue(1'b1, LLDC, 32'hffff_ffff, 32'hffff_ffff, '0);
    idle(2);
  endtask

  task automatic run_random();
    logic [31:0] sel;
    repeat (NUM_RANDOM) begin
      sel = $random(seed);
      issue(sel[2:0] != 3'd0, alu_op_e'(sel[7:4]), pick_operand(), pick_operand(), sel[12:8]);
    end
  endtask

  initial begin
    seed       = 32'h5d25_5cc9;
    model_cnt  = '0;
    acc_cnt    = '0;
    pend_valid = 1'b0;
    last_rsp   = '0;
    arst_n     = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    compare("rsp_valid after reset", word_t'(rsp_valid), 32'd0);
    compare("perf_cnt after reset", perf_cnt, 32'd0);
    compare("result after reset", rsp.result, 32'd0);
    run_directed();
    run_random();
    // Drain the last response
    idle(1);
    if (exp_q.size() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("The run ended with %0d responses never checked", exp_q.size());
      $display("STATUS: FAIL");
      $fatal(1, "unchecked responses");
    end
  end

endmodule
